// ==== vlog.f ====
common/lc3b_types.sv
control/control_rom.sv
control/cpu_sequencer.sv
datapath/regfile.sv
datapath/alu.sv
datapath/datapath.sv
verilog/lc3b_core.sv
bench/wb_memory_model.sv
bench/tb_lc3b_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the LC-3b core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_lc3b_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_lc3b_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qxF '** PASS **' <<< "$output"; then
    exit 0
fi
exit 1

// ==== bench/tb_lc3b_core.sv ====
`timescale 1ns/10ps

module tb_lc3b_core;

    logic        clk, rst, wait_en;
    logic [14:0] wb_adr;
    logic [15:0] wb_wdata, wb_rdata;
    logic [1:0]  wb_sel;
    logic        wb_we, wb_cyc, wb_stb, wb_ack;
    logic [15:0] prog [$];
    logic [15:0] bus_log [$];  // {we, word address} per acked access
    logic [14:0] pend_adr;
    logic        pend, pend_we, marker_seen;
    logic [15:0] a, b;
    logic [31:0] rnd;
    int          seed, errors, timeouts;

    lc3b_core i_lc3b_core (.clk(clk), .rst(rst), .wb_adr(wb_adr), .wb_wdata(wb_wdata),
        .wb_rdata(wb_rdata), .wb_we(wb_we), .wb_sel(wb_sel), .wb_cyc(wb_cyc),
        .wb_stb(wb_stb), .wb_ack(wb_ack));

    wb_memory_model i_memory (.clk(clk), .rst(rst), .wait_en(wait_en), .wb_adr(wb_adr),
        .wb_wdata(wb_wdata), .wb_we(wb_we), .wb_sel(wb_sel), .wb_cyc(wb_cyc),
        .wb_stb(wb_stb), .wb_rdata(wb_rdata), .wb_ack(wb_ack));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Bus watcher, an open request must hold until ack
    always @(negedge clk) begin
        if (rst) begin
            pend = 1'b0;
        end else begin
            if (pend) begin
                assert (wb_cyc && wb_stb && wb_adr == pend_adr && wb_we == pend_we) else begin
                    errors++;
                    $display("bus request changed or dropped before ack at %0t", $time);
                end
            end
            if (wb_cyc && wb_stb) begin
                assert (wb_sel == 2'b11) else begin
                    errors++;
                    $display("mismatch at %0t: wb_sel is %b, expected 11", $time, wb_sel);
                end
            end
            if (wb_cyc && wb_stb && wb_ack) begin
                bus_log.push_back({wb_we, wb_adr});
                if (wb_we && wb_adr == 15'h00f0) marker_seen = 1'b1;
            end
            pend     = wb_cyc && wb_stb && !wb_ack;
            pend_adr = wb_adr;
            pend_we  = wb_we;
        end
    end

    function automatic logic [15:0] reg_form(int op, int dr, int sr1, int sr2);
        return {op[3:0], dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
    endfunction

    function automatic logic [15:0] imm_form(int op, int dr, int sr1, int imm);
        return {op[3:0], dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic logic [15:0] mem_form(int op, int r, int base, int off);
        return {op[3:0], r[2:0], base[2:0], off[5:0]};
    endfunction

    function automatic logic [15:0] branch(int nzp, int off);
        return {4'b0000, nzp[2:0], off[8:0]};
    endfunction

    function automatic logic [2:0] cc_of(logic [15:0] v);
        return v[15] ? 3'b100 : (v == 16'd0 ? 3'b010 : 3'b001);
    endfunction

    function automatic int log_hits(logic we, int word);
        int hits;
        hits = 0;
        foreach (bus_log[i]) begin
            if (bus_log[i] == {we, word[14:0]}) hits++;
        end
        return hits;
    endfunction

    // Data words sit around R6, which points at word 0xE0
    task automatic set_data(int off, logic [15:0] value);
        int idx;
        idx = 224 + off;
        i_memory.mem[idx[7:0]] = value;
    endtask

    task automatic check_word(int off, logic [15:0] exp);
        int idx;
        logic [15:0] got;
        idx = 224 + off;
        got = i_memory.mem[idx[7:0]];
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: word %0h is %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_true(logic ok, string what);
        assert (ok) else begin
            errors++;
            $display("mismatch at %0t: %s", $time, what);
        end
    endtask

    task automatic begin_program();
        @(negedge clk);
        rst = 1'b1;
        prog.delete();
        for (int i = 0; i < 256; i++) begin
            i_memory.mem[i] = {i[7:0] ^ 8'hc3, ~i[7:0]};
        end
    endtask

    task automatic run_program();
        int cycles;
        prog.push_back(mem_form(7, 6, 6, 16));  // Marker store
        prog.push_back(branch(7, -1));
        i_memory.mem[0]  = mem_form(6, 6, 7, 31);  // R6 = pointer in word 31
        i_memory.mem[1]  = branch(7, 30);          // Jump to word 32
        i_memory.mem[31] = 16'h01c0;
        foreach (prog[i]) i_memory.mem[32 + i] = prog[i];
        bus_log.delete();
        marker_seen = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (!marker_seen && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        if (!marker_seen) begin
            timeouts++;
            $display("timeout: the program never stored to the marker address");
        end
    endtask

    task automatic test_register_arith();
        begin_program();
        set_data(0, a);
        set_data(1, b);
        prog = '{mem_form(6, 1, 6, 0), mem_form(6, 2, 6, 1), reg_form(1, 3, 1, 2),
                 reg_form(5, 4, 1, 2), mem_form(7, 3, 6, 17), mem_form(7, 4, 6, 18)};
        run_program();
        check_word(17, a + b);
        check_word(18, a & b);
    endtask

    task automatic test_immediates();
        begin_program();
        set_data(0, a);
        prog = '{mem_form(6, 1, 6, 0), imm_form(1, 2, 1, -7), imm_form(5, 3, 1, -4),
                 imm_form(5, 4, 1, 11), imm_form(1, 5, 1, 15), imm_form(9, 0, 1, -1),
                 mem_form(7, 2, 6, 17), mem_form(7, 3, 6, 18), mem_form(7, 4, 6, 19),
                 mem_form(7, 5, 6, 20), mem_form(7, 0, 6, 21)};
        run_program();
        check_word(17, a + 16'hfff9);
        check_word(18, a & 16'hfffc);
        check_word(19, a & 16'h000b);
        check_word(20, a + 16'h000f);
        check_word(21, ~a);
    endtask

    task automatic test_addressing();
        begin_program();
        set_data(5, a);
        set_data(-3, b);
        prog = '{mem_form(6, 1, 6, 5), mem_form(6, 2, 6, -3), mem_form(7, 1, 6, -8),
                 mem_form(7, 2, 6, 20)};
        run_program();
        check_word(-8, a);
        check_word(20, b);
        check_true(log_hits(1'b0, 'he5) == 1, "no load seen at word e5");
        check_true(log_hits(1'b0, 'hdd) == 1, "no load seen at word dd");
        check_true(log_hits(1'b1, 'hd8) == 1, "no store seen at word d8");
        check_true(log_hits(1'b1, 'hf4) == 1, "no store seen at word f4");
    endtask

    // One case per nzp mask, STR of a positive value between load and branch
    task automatic test_branches(logic [15:0] v);
        begin_program();
        set_data(2, v);
        prog = '{imm_form(1, 3, 7, 1), imm_form(1, 4, 7, 2)};
        for (int m = 1; m < 8; m++) begin
            prog.push_back(mem_form(6, 1, 6, 2));
            prog.push_back(mem_form(7, 3, 6, -1));
            prog.push_back(branch(m, 2));
            prog.push_back(mem_form(7, 3, 6, 16 + m));  // Not taken
            prog.push_back(branch(7, 1));
            prog.push_back(mem_form(7, 4, 6, 16 + m));  // Taken
        end
        run_program();
        for (int m = 1; m < 8; m++) begin
            check_word(16 + m, (m[2:0] & cc_of(v)) != 3'b000 ? 16'd2 : 16'd1);
        end
    endtask

    task automatic test_unknown_opcode();
        begin_program();
        set_data(0, a);
        prog = '{mem_form(6, 1, 6, 0), imm_form(1, 2, 1, 3), 16'hd2bf,
                 mem_form(7, 1, 6, 17), mem_form(7, 2, 6, 18), mem_form(7, 0, 6, 19)};
        run_program();
        check_word(17, a);
        check_word(18, a + 16'd3);
        check_word(19, 16'd0);
        check_true(log_hits(1'b1, 'hf1) + log_hits(1'b1, 'hf2) + log_hits(1'b1, 'hf3)
                   + log_hits(1'b1, 'hf0) == 4, "unexpected store count");
        foreach (bus_log[i]) check_true(bus_log[i][15] == 1'b0 || bus_log[i][14:8] == 7'd0 &&
            bus_log[i][7:0] >= 8'hf0 && bus_log[i][7:0] <= 8'hf3, "store to a stray address");
    endtask

    initial begin
        rst = 1'b1;
        wait_en = 1'b0;
        errors = 0;
        timeouts = 0;
        seed = 32'hc21b3e8c;
        rnd = $random(seed);
        a = rnd[15:0];
        rnd = $random(seed);
        b = rnd[15:0];
        for (int pass = 0; pass < 2; pass++) begin
            @(negedge clk);
            wait_en = (pass == 1);  // Second pass runs with random wait states
            test_register_arith();
            test_immediates();
            test_addressing();
            test_branches(16'h8123);
            test_branches(16'h0000);
            test_branches(16'h1234);
            test_unknown_opcode();
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_lc3b_core

// ==== bench/wb_memory_model.sv ====
`timescale 1ns/10ps

module wb_memory_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        wait_en,
    input  logic [14:0] wb_adr,
    input  logic [15:0] wb_wdata,
    input  logic        wb_we,
    input  logic [1:0]  wb_sel,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    output logic [15:0] wb_rdata,
    output logic        wb_ack
);

    logic [15:0] mem [256];
    logic        busy;
    logic [1:0]  wait_left;
    logic [1:0]  waits;
    logic [31:0] rnd;
    int          seed;

    initial seed = 32'hc21b3e8c;

    assign wb_rdata = mem[wb_adr[7:0]];  // Only 256 words decoded

    always @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            busy      <= 1'b0;
            wait_left <= 2'd0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
            busy   <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (busy) begin
                waits = wait_left;
            end else begin
                rnd   = $random(seed);
                waits = wait_en ? rnd[1:0] : 2'd0;  // 0 to 3 wait states
            end
            if (waits == 2'd0) begin
                wb_ack <= 1'b1;
                if (wb_we && wb_sel[0]) mem[wb_adr[7:0]][7:0] = wb_wdata[7:0];
                if (wb_we && wb_sel[1]) mem[wb_adr[7:0]][15:8] = wb_wdata[15:8];
            end else begin
                busy      <= 1'b1;
                wait_left <= waits - 2'd1;
            end
        end
    end

endmodule : wb_memory_model

// ==== verilog/lc3b_core.sv ====
`timescale 1ns/10ps

module lc3b_core (
    input  logic                                clk,
    input  logic                                rst,
    output logic [lc3b_types::wb_adr_width-1:0] wb_adr,
    output lc3b_types::lc3b_word                wb_wdata,
    input  lc3b_types::lc3b_word                wb_rdata,
    output logic                                wb_we,
    output logic [lc3b_types::wb_sel_width-1:0] wb_sel,
    output logic                                wb_cyc,
    output logic                                wb_stb,
    input  logic                                wb_ack
);

    lc3b_types::lc3b_control_word ctrl;
    lc3b_types::lc3b_opcode       ir_opcode;
    logic ir_imm;
    logic load_ir, load_pc, load_mar, load_mdr;
    logic addr_from_mar, writeback;

    assign wb_sel = '1;  // Word accesses only

    cpu_sequencer i_sequencer (
        .clk           (clk),
        .rst           (rst),
        .ctrl          (ctrl),
        .wb_ack        (wb_ack),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .load_ir       (load_ir),
        .load_pc       (load_pc),
        .load_mar      (load_mar),
        .load_mdr      (load_mdr),
        .addr_from_mar (addr_from_mar),
        .writeback     (writeback)
    );

    control_rom i_control_rom (
        .opcode    (ir_opcode),
        .imm_check (ir_imm),
        .ctrl      (ctrl)
    );

    datapath i_datapath (
        .clk           (clk),
        .rst           (rst),
        .ctrl          (ctrl),
        .load_ir       (load_ir),
        .load_pc       (load_pc),
        .load_mar      (load_mar),
        .load_mdr      (load_mdr),
        .addr_from_mar (addr_from_mar),
        .writeback     (writeback),
        .wb_rdata      (wb_rdata),
        .wb_adr        (wb_adr),
        .wb_wdata      (wb_wdata),
        .ir_opcode     (ir_opcode),
        .ir_imm        (ir_imm)
    );

endmodule : lc3b_core

// ==== datapath/datapath.sv ====
`timescale 1ns/10ps

module datapath (
    input  logic                                  clk,
    input  logic                                  rst,
    input  lc3b_types::lc3b_control_word          ctrl,
    input  logic                                  load_ir,
    input  logic                                  load_pc,
    input  logic                                  load_mar,
    input  logic                                  load_mdr,
    input  logic                                  addr_from_mar,
    input  logic                                  writeback,
    input  lc3b_types::lc3b_word                  wb_rdata,
    output logic [lc3b_types::wb_adr_width-1:0]   wb_adr,
    output lc3b_types::lc3b_word                  wb_wdata,
    output lc3b_types::lc3b_opcode                ir_opcode,
    output logic                                  ir_imm
);

    lc3b_types::lc3b_word pc, ir, mar, mdr;
    logic [2:0] cc;  // n z p

    lc3b_types::lc3b_word rdata_a, rdata_b;
    lc3b_types::lc3b_word sext_imm5, offset6, pcoffset9;
    lc3b_types::lc3b_word alu_b, alu_f;
    lc3b_types::lc3b_word addr_base, addr_off, addr_sum;
    lc3b_types::lc3b_word wdata;
    lc3b_types::lc3b_reg  raddr_b;
    logic reg_we;
    logic branch_taken;

    assign ir_opcode = lc3b_types::lc3b_opcode'(ir[15:12]);
    assign ir_imm    = ir[5];

    assign sext_imm5 = {{11{ir[4]}}, ir[4:0]};
    assign offset6   = {{9{ir[5]}}, ir[5:0], 1'b0};  // Byte offset, doubled
    assign pcoffset9 = {{6{ir[8]}}, ir[8:0], 1'b0};

    // STR reads its source register on port b
    assign raddr_b = ctrl.mem_write ? ir[11:9] : ir[2:0];

    regfile i_regfile (
        .clk     (clk),
        .rst     (rst),
        .we      (reg_we),
        .waddr   (ir[11:9]),
        .wdata   (wdata),
        .raddr_a (ir[8:6]),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    assign alu_b = ctrl.sr2mux_sel ? sext_imm5 : rdata_b;

    alu i_alu (
        .aluop (ctrl.aluop),
        .a     (rdata_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    // Shared address adder for MAR and branch target
    assign addr_base = ctrl.addr_sel ? rdata_a : pc;
    assign addr_off  = ctrl.addr_sel ? offset6 : pcoffset9;
    assign addr_sum  = addr_base + addr_off;

    assign branch_taken = ctrl.is_branch && |(ir[11:9] & cc);
    assign wdata        = ctrl.regfilemux_sel ? mdr : alu_f;
    assign reg_we       = writeback && ctrl.load_regfile;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            cc <= 3'b000;
        end else begin
            if (load_pc) begin
                pc <= pc + 16'd2;
            end else if (writeback && branch_taken) begin
                pc <= addr_sum;  // PC already points past the BR
            end
            if (writeback && ctrl.load_cc) begin
                cc <= {wdata[15], wdata == '0, !wdata[15] && (wdata != '0)};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ir) ir <= wb_rdata;
        if (load_mar) mar <= addr_sum;
        if (load_mdr) mdr <= ctrl.mem_write ? rdata_b : wb_rdata;
    end

    assign wb_adr   = addr_from_mar ? mar[15:1] : pc[15:1];
    assign wb_wdata = mdr;

    a_cc_stays_onehot: assert property (@(posedge clk) disable iff (rst)
        (cc != 3'b000) |=> $onehot(cc));

endmodule : datapath

// ==== datapath/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  lc3b_types::alu_ops   aluop,
    input  lc3b_types::lc3b_word a,
    input  lc3b_types::lc3b_word b,
    output lc3b_types::lc3b_word f
);

    always_comb begin
        case (aluop)
            lc3b_types::alu_add: f = a + b;
            lc3b_types::alu_and: f = a & b;
            lc3b_types::alu_not: f = ~a;
            default:             f = a;  // Pass
        endcase
    end

endmodule : alu

// ==== datapath/regfile.sv ====
`timescale 1ns/10ps

module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we,
    input  lc3b_types::lc3b_reg  waddr,
    input  lc3b_types::lc3b_word wdata,
    input  lc3b_types::lc3b_reg  raddr_a,
    input  lc3b_types::lc3b_reg  raddr_b,
    output lc3b_types::lc3b_word rdata_a,
    output lc3b_types::lc3b_word rdata_b
);

    lc3b_types::lc3b_word regs [lc3b_types::reg_count];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < lc3b_types::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads, a write shows up after the edge
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule : regfile

// ==== control/cpu_sequencer.sv ====
`timescale 1ns/10ps

module cpu_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  lc3b_types::lc3b_control_word ctrl,
    input  logic                         wb_ack,
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output logic                         load_ir,
    output logic                         load_pc,
    output logic                         load_mar,
    output logic                         load_mdr,
    output logic                         addr_from_mar,
    output logic                         writeback
);

    lc3b_types::seq_state state;
    logic bus_done;
    logic mem_op;

    assign bus_done = wb_cyc && wb_ack;
    assign mem_op   = ctrl.mem_read || ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= lc3b_types::s_fetch;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else begin
            case (state)
                lc3b_types::s_fetch: begin
                    if (bus_done) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        state  <= lc3b_types::s_decode;
                    end else begin
                        wb_cyc <= 1'b1;  // Only needed for the first fetch after reset
                        wb_stb <= 1'b1;
                    end
                end
                lc3b_types::s_decode: state <= lc3b_types::s_execute;
                lc3b_types::s_execute: begin
                    if (mem_op) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= ctrl.mem_write;
                        state  <= lc3b_types::s_memory;
                    end else begin
                        state <= lc3b_types::s_writeback;
                    end
                end
                lc3b_types::s_memory: begin
                    if (bus_done) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        state  <= lc3b_types::s_writeback;
                    end
                end
                default: begin
                    // Writeback, request the next fetch right away
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                    state  <= lc3b_types::s_fetch;
                end
            endcase
        end
    end

    always_comb begin
        load_ir       = (state == lc3b_types::s_fetch) && bus_done;
        load_pc       = load_ir;
        load_mar      = (state == lc3b_types::s_execute);
        load_mdr      = ((state == lc3b_types::s_execute) && ctrl.mem_write) ||
                        ((state == lc3b_types::s_memory) && ctrl.mem_read && bus_done);
        addr_from_mar = (state == lc3b_types::s_memory);
        writeback     = (state == lc3b_types::s_writeback);
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc);

    a_we_store_only: assert property (@(posedge clk) disable iff (rst)
        wb_we |-> (state == lc3b_types::s_memory) && (ctrl.opcode == lc3b_types::op_str));

endmodule : cpu_sequencer

// ==== control/control_rom.sv ====
`timescale 1ns/10ps

module control_rom (
    input  lc3b_types::lc3b_opcode       opcode,
    input  logic                         imm_check,
    output lc3b_types::lc3b_control_word ctrl
);

    always_comb begin
        // Defaults
        ctrl.opcode         = opcode;
        ctrl.aluop          = lc3b_types::alu_pass;
        ctrl.load_cc        = 1'b0;
        ctrl.load_regfile   = 1'b0;
        ctrl.sr2mux_sel     = 1'b0;
        ctrl.mem_read       = 1'b0;
        ctrl.mem_write      = 1'b0;
        ctrl.addr_sel       = 1'b0;
        ctrl.regfilemux_sel = 1'b0;
        ctrl.is_branch      = 1'b0;

        case (opcode)
            lc3b_types::op_add: begin
                ctrl.aluop        = lc3b_types::alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.sr2mux_sel   = imm_check;  // imm5 form when IR[5] set
            end

            lc3b_types::op_and: begin
                ctrl.aluop        = lc3b_types::alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.sr2mux_sel   = imm_check;
            end

            lc3b_types::op_not: begin
                ctrl.aluop        = lc3b_types::alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end

            lc3b_types::op_ldr: begin
                ctrl.mem_read       = 1'b1;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
                ctrl.addr_sel       = 1'b1;
                ctrl.regfilemux_sel = 1'b1;
            end

            // Store leaves cc alone
            lc3b_types::op_str: begin
                ctrl.mem_write = 1'b1;
                ctrl.addr_sel  = 1'b1;
            end

            lc3b_types::op_br: begin
                ctrl.is_branch = 1'b1;  // PC-relative target
            end

            default: begin
                ctrl = '0;  // Runs as a no-op
            end
        endcase
    end

endmodule : control_rom

// ==== common/lc3b_types.sv ====
package lc3b_types;

    localparam int word_width     = 16;
    localparam int reg_count      = 8;
    localparam int reg_addr_width = $clog2(reg_count);
    localparam int wb_adr_width   = word_width - 1;  // Word address, byte bit dropped
    localparam int wb_sel_width   = word_width / 8;

    typedef logic [word_width-1:0]     lc3b_word;
    typedef logic [reg_addr_width-1:0] lc3b_reg;

    // Opcode field encodings, IR[15:12]
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } alu_ops;

    typedef enum logic [2:0] {
        s_fetch,
        s_decode,
        s_execute,
        s_memory,
        s_writeback
    } seq_state;

    // Decoded control for the instruction in IR
    typedef struct packed {
        lc3b_opcode opcode;
        alu_ops     aluop;
        logic       load_cc;
        logic       load_regfile;
        logic       sr2mux_sel;      // 1 selects sign-extended imm5
        logic       mem_read;
        logic       mem_write;
        logic       addr_sel;        // 1 selects base + offset6
        logic       regfilemux_sel;  // 1 selects MDR
        logic       is_branch;
    } lc3b_control_word;

endpackage : lc3b_types
